//--- verilog/lsuCachePkg.sv
// Cache line geometry and the processor side request shapes

package lsuCachePkg;

  //////////////////////////////////////////////////
  // Line geometry
  //////////////////////////////////////////////////

  localparam int addressBits = 32;
  localparam int wordBits = 32;
  localparam int wordsPerLine = 4;
  localparam int wordIndexBits = 2;
  localparam int byteOffsetBits = 2;
  localparam int lineBits = wordsPerLine * wordBits;

  // Address split as the cache sees it
  typedef struct packed {
    logic [addressBits-wordIndexBits-byteOffsetBits-1:0] lineNumber;
    logic [wordIndexBits-1:0] wordIndex;
    logic [byteOffsetBits-1:0] byteOffset;
  } lsuLineView;

  // One address word, read either flat or split into line fields
  typedef union packed {
    logic [addressBits-1:0] byteAddress;
    lsuLineView lineView;
  } lsuAddress;

  //////////////////////////////////////////////////
  // Processor request
  //////////////////////////////////////////////////

  // rw bit 1 asks for a read and bit 0 for a write
  typedef struct packed {
    logic [1:0] rw;
    logic cacheable;
    lsuAddress address;
    logic [wordBits-1:0] writeData;
  } lsuRequest;

  // Word 0 of the line sits in the low bits
  typedef logic [wordsPerLine-1:0][wordBits-1:0] lineData;

endpackage

//--- verilog/wishbonePkg.sv
// Wishbone classic bus shapes shared by the master and the request producer

package wishbonePkg;

  localparam int wbAddrBits = 32;
  localparam int wbDataBits = 32;
  localparam int wbSelBits = 4;

  // One word transfer as asked for by the producer
  typedef struct packed {
    logic write;
    logic [wbAddrBits-1:0] address;
    logic [wbDataBits-1:0] data;
  } wbWordRequest;

  // Master to slave signals
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [wbAddrBits-1:0] adr;
    logic [wbDataBits-1:0] datW;
    logic [wbSelBits-1:0] sel;
  } wbBusOut;

  // Slave to master signals
  typedef struct packed {
    logic ack;
    logic [wbDataBits-1:0] datR;
  } wbBusIn;

endpackage

//--- verilog/lsuBusFsm.sv
`timescale 1ns/1ns

// Decides which bus transaction runs and steps through the words of a line

module lsuBusFsm (
  input  logic clk,
  input  logic reset,
  input  lsuCachePkg::lsuRequest request,
  input  logic ignoreRequest,
  input  logic cpuBusy,
  input  logic fetchLine,
  input  logic writeLine,
  input  lsuCachePkg::lsuAddress lineAddress,
  input  logic [lsuCachePkg::wordBits-1:0] bufferWord,
  input  logic wordDone,
  input  logic [lsuCachePkg::wordBits-1:0] wordReadData,
  output wishbonePkg::wbWordRequest wordRequest,
  output logic wordValid,
  output logic loadLine,
  output logic captureWord,
  output logic [lsuCachePkg::wordIndexBits-1:0] wordIndex,
  output logic busStall,
  output logic busCommitted,
  output logic transComplete,
  output logic [lsuCachePkg::wordBits-1:0] readData,
  output logic cacheBusAck
);

  typedef enum logic [2:0] {
    stateReady,
    stateUncachedWrite,
    stateUncachedWriteDone,
    stateUncachedRead,
    stateUncachedReadDone,
    stateCpuBusyWait,
    stateLineFetch,
    stateLineWrite
  } busState;

  busState state;
  busState nextState;

  logic [lsuCachePkg::wordIndexBits-1:0] wordCount;
  logic lastWord;
  logic uncachedWrite;
  logic uncachedRead;
  logic inUncached;
  logic inLine;
  lsuCachePkg::lsuAddress beatAddress;

  //////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////

  // Cacheable accesses are served by the cache and only reach us as line traffic
  assign uncachedWrite = request.rw[0] & ~request.cacheable;
  assign uncachedRead = request.rw[1] & ~request.cacheable;

  assign inUncached = (state == stateUncachedWrite) | (state == stateUncachedRead);
  assign inLine = (state == stateLineFetch) | (state == stateLineWrite);

  //////////////////////////////////////////////////
  // State register and next state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stateReady: begin
        // Uncached write wins, then read, then fetch, then writeback
        if (ignoreRequest) begin
          nextState = stateReady;
        end else if (uncachedWrite) begin
          nextState = stateUncachedWrite;
        end else if (uncachedRead) begin
          nextState = stateUncachedRead;
        end else if (fetchLine) begin
          nextState = stateLineFetch;
        end else if (writeLine) begin
          nextState = stateLineWrite;
        end
      end
      stateUncachedWrite: begin
        if (wordDone) nextState = stateUncachedWriteDone;
      end
      stateUncachedRead: begin
        if (wordDone) nextState = stateUncachedReadDone;
      end
      stateUncachedWriteDone, stateUncachedReadDone: begin
        nextState = cpuBusy ? stateCpuBusyWait : stateReady;
      end
      stateCpuBusyWait: begin
        if (!cpuBusy) nextState = stateReady;
      end
      stateLineFetch, stateLineWrite: begin
        if (wordDone && lastWord) nextState = stateReady;
      end
      default: nextState = stateReady;
    endcase
  end

  //////////////////////////////////////////////////
  // Word counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || state == stateReady) begin
      wordCount <= '0;
    end else if (inLine && wordDone) begin
      wordCount <= wordCount + lsuCachePkg::wordIndexBits'(1);
    end
  end

  assign lastWord = wordCount == lsuCachePkg::wordIndexBits'(lsuCachePkg::wordsPerLine - 1);
  assign wordIndex = wordCount;

  // Beats walk up from the start of the line
  always_comb begin
    beatAddress = lineAddress;
    beatAddress.lineView.wordIndex = wordCount;
    beatAddress.lineView.byteOffset = '0;
  end

  //////////////////////////////////////////////////
  // Word request to the bus master
  //////////////////////////////////////////////////

  // Held high through the wordDone cycle, the master ignores it there
  assign wordValid = inUncached | inLine;

  always_comb begin
    wordRequest.write = (state == stateUncachedWrite) | (state == stateLineWrite);
    if (inLine) begin
      wordRequest.address = beatAddress.byteAddress;
    end else begin
      wordRequest.address = request.address.byteAddress;
    end
    if (state == stateLineWrite) begin
      wordRequest.data = bufferWord;
    end else begin
      wordRequest.data = request.writeData;
    end
  end

  //////////////////////////////////////////////////
  // Buffer controls and status
  //////////////////////////////////////////////////

  // Line is copied into the buffer as the writeback leaves the ready state
  assign loadLine = (state == stateReady) & ~ignoreRequest & ~uncachedWrite & ~uncachedRead &
                    ~fetchLine & writeLine;
  assign captureWord = (state == stateLineFetch) & wordDone;

  assign busStall = ((state == stateReady) & ~ignoreRequest &
                     (uncachedWrite | uncachedRead | fetchLine | writeLine)) |
                    inUncached | inLine;
  assign busCommitted = state != stateReady;
  assign transComplete = inUncached & wordDone;
  assign cacheBusAck = inLine & wordDone & lastWord;

  // The master keeps its read register until the next ack
  assign readData = wordReadData;

  // A word request is only withdrawn once the master has finished it
  wordValidHeld: assert property (@(posedge clk) disable iff (reset)
    $fell(wordValid) |-> $past(wordDone));

  // The last beat wraps the counter back to word 0 for the next line
  lastBeatAck: assert property (@(posedge clk) disable iff (reset)
    cacheBusAck |=> wordIndex == '0);

endmodule

//--- verilog/lineBuffer.sv
`timescale 1ns/1ns

// Holds one cache line while it moves between the cache and the bus
//
// A fetch fills the line one word per bus beat. A writeback loads the
// whole line from the cache in one cycle and then hands it out a word
// at a time.

module lineBuffer (
  input  logic clk,
  input  logic reset,
  input  logic loadLine,
  input  lsuCachePkg::lineData lineIn,
  input  logic captureWord,
  input  logic [lsuCachePkg::wordIndexBits-1:0] wordIndex,
  input  logic [lsuCachePkg::wordBits-1:0] wordReadData,
  output lsuCachePkg::lineData lineOut,
  output logic [lsuCachePkg::wordBits-1:0] bufferWord
);

  lsuCachePkg::lineData lineReg;

  //////////////////////////////////////////////////
  // Line storage
  //////////////////////////////////////////////////

  // A writeback loads the whole line and a fetch writes one word per beat
  always_ff @(posedge clk) begin
    if (loadLine) begin
      lineReg <= lineIn;
    end else if (captureWord) begin
      lineReg[wordIndex] <= wordReadData;
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Cache sees the whole line, complete once the last beat is captured
  assign lineOut = lineReg;

  // Writeback data for the beat that is running now
  assign bufferWord = lineReg[wordIndex];

  // A fetch and a writeback never overlap
  loadOrCapture: assert property (@(posedge clk) disable iff (reset)
    !(loadLine && captureWord));

endmodule

//--- verilog/wishboneMaster.sv
`timescale 1ns/1ns

// Wishbone classic master, one bus cycle for each word request

module wishboneMaster (
  input  logic clk,
  input  logic reset,
  input  wishbonePkg::wbWordRequest wordRequest,
  input  logic wordValid,
  input  wishbonePkg::wbBusIn wbIn,
  output wishbonePkg::wbBusOut wbOut,
  output logic wordDone,
  output logic [wishbonePkg::wbDataBits-1:0] wordReadData
);

  typedef enum logic {
    stateIdle,
    stateCycle
  } masterState;

  masterState state;
  logic startCycle;
  wishbonePkg::wbWordRequest heldRequest;

  //////////////////////////////////////////////////
  // Cycle control
  //////////////////////////////////////////////////

  // wordValid is still high while wordDone is out, so that cycle must not restart
  assign startCycle = (state == stateIdle) & wordValid & ~wordDone;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateIdle;
      wordDone <= 1'b0;
    end else begin
      wordDone <= 1'b0;
      case (state)
        stateIdle: begin
          if (startCycle) state <= stateCycle;
        end
        stateCycle: begin
          if (wbIn.ack) begin
            state <= stateIdle;
            wordDone <= 1'b1;
          end
        end
        default: state <= stateIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (startCycle) begin
      heldRequest <= wordRequest;
    end
  end

  // Read data stays put until the next ack
  always_ff @(posedge clk) begin
    if (state == stateCycle && wbIn.ack) begin
      wordReadData <= wbIn.datR;
    end
  end

  //////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////

  // cyc and stb come straight from the state flop
  assign wbOut.cyc = state == stateCycle;
  assign wbOut.stb = state == stateCycle;
  assign wbOut.we = heldRequest.write;
  assign wbOut.adr = heldRequest.address;
  assign wbOut.datW = heldRequest.data;
  assign wbOut.sel = '1;

  // Slave may stretch the cycle, the address must not move meanwhile
  adrStable: assert property (@(posedge clk) disable iff (reset)
    (wbOut.stb && !wbIn.ack) |=> $stable(wbOut.adr));

endmodule

//--- verilog/lsuBusUnit.sv
`timescale 1ns/1ns

// Bus side of the load/store unit
//
// The state machine picks the transaction, the line buffer holds cache
// line data, and the master runs each word on the Wishbone port.

module lsuBusUnit (
  input  logic clk,
  input  logic reset,
  input  lsuCachePkg::lsuRequest request,
  input  logic ignoreRequest,
  input  logic cpuBusy,
  output logic busStall,
  output logic busCommitted,
  output logic transComplete,
  output logic [lsuCachePkg::wordBits-1:0] readData,
  input  logic fetchLine,
  input  logic writeLine,
  input  lsuCachePkg::lsuAddress lineAddress,
  input  lsuCachePkg::lineData lineIn,
  output lsuCachePkg::lineData lineOut,
  output logic cacheBusAck,
  output wishbonePkg::wbBusOut wbOut,
  input  wishbonePkg::wbBusIn wbIn
);

  wishbonePkg::wbWordRequest wordRequest;
  logic wordValid;
  logic wordDone;
  logic [wishbonePkg::wbDataBits-1:0] wordReadData;
  logic loadLine;
  logic captureWord;
  logic [lsuCachePkg::wordIndexBits-1:0] wordIndex;
  logic [lsuCachePkg::wordBits-1:0] bufferWord;

  //////////////////////////////////////////////////
  // Transaction control
  //////////////////////////////////////////////////

  lsuBusFsm busFsm (
    .clk(clk),
    .reset(reset),
    .request(request),
    .ignoreRequest(ignoreRequest),
    .cpuBusy(cpuBusy),
    .fetchLine(fetchLine),
    .writeLine(writeLine),
    .lineAddress(lineAddress),
    .bufferWord(bufferWord),
    .wordDone(wordDone),
    .wordReadData(wordReadData),
    .wordRequest(wordRequest),
    .wordValid(wordValid),
    .loadLine(loadLine),
    .captureWord(captureWord),
    .wordIndex(wordIndex),
    .busStall(busStall),
    .busCommitted(busCommitted),
    .transComplete(transComplete),
    .readData(readData),
    .cacheBusAck(cacheBusAck)
  );

  //////////////////////////////////////////////////
  // Line data and bus port
  //////////////////////////////////////////////////

  lineBuffer buffer (
    .clk(clk),
    .reset(reset),
    .loadLine(loadLine),
    .lineIn(lineIn),
    .captureWord(captureWord),
    .wordIndex(wordIndex),
    .wordReadData(wordReadData),
    .lineOut(lineOut),
    .bufferWord(bufferWord)
  );

  wishboneMaster master (
    .clk(clk),
    .reset(reset),
    .wordRequest(wordRequest),
    .wordValid(wordValid),
    .wbIn(wbIn),
    .wbOut(wbOut),
    .wordDone(wordDone),
    .wordReadData(wordReadData)
  );

endmodule

//--- testbench/wishboneMemModel.sv
`timescale 1ns/1ns

// Wishbone classic slave memory that stretches each cycle by a random delay

module wishboneMemModel (
  input  logic clk,
  input  logic reset,
  input  wishbonePkg::wbBusOut wbOut,
  output wishbonePkg::wbBusIn wbIn
);

  localparam int memWords = 256;
  localparam logic [31:0] fillPattern = 32'h5ca1ab1e;

  logic [31:0] mem [memWords];
  logic ack;
  logic [31:0] readWord;
  logic started;
  logic [1:0] delayLeft;

  assign wbIn.ack = ack;
  assign wbIn.datR = readWord;

  // Random delays all come from this one process
  initial begin
    void'($urandom(32'hc156fc7a));
    // Each word starts as its own byte address mixed with a constant
    for (int i = 0; i < memWords; i++) begin
      mem[i] = 32'(i * 4) ^ fillPattern;
    end
    ack = 1'b0;
    readWord = '0;
    started = 1'b0;
    delayLeft = '0;
    forever begin
      @(posedge clk);
      ack <= 1'b0;
      if (reset) begin
        started <= 1'b0;
      end else if (wbOut.cyc && wbOut.stb && !ack) begin
        if (!started) begin
          started <= 1'b1;
          delayLeft <= 2'($urandom % 4);
        end else if (delayLeft != 0) begin
          delayLeft <= delayLeft - 2'd1;
        end else begin
          started <= 1'b0;
          ack <= 1'b1;
          readWord <= mem[wbOut.adr[9:2]];
          if (wbOut.we) mem[wbOut.adr[9:2]] <= wbOut.datW;
        end
      end
    end
  end

endmodule

//--- testbench/lsuBusUnitTb.sv
`timescale 1ns/1ns

// Drives the bus unit from the processor and cache sides against a memory model

module lsuBusUnitTb;

  localparam int timeoutCycles = 100;
  localparam logic [31:0] fillPattern = 32'h5ca1ab1e;

  logic clk;
  logic reset;
  lsuCachePkg::lsuRequest request;
  logic ignoreRequest;
  logic cpuBusy;
  logic busStall;
  logic busCommitted;
  logic transComplete;
  logic [31:0] readData;
  logic fetchLine;
  logic writeLine;
  lsuCachePkg::lsuAddress lineAddress;
  lsuCachePkg::lineData lineIn;
  lsuCachePkg::lineData lineOut;
  logic cacheBusAck;
  wishbonePkg::wbBusOut wbOut;
  wishbonePkg::wbBusIn wbIn;

  // Every finished bus cycle, in order
  logic [31:0] seenAdr [$];
  logic [31:0] seenData [$];
  logic seenWe [$];

  string testName;
  int errorCount;
  int testErrorsAtStart;
  int testsRun;
  int testsOk;
  int firstBeat;

  lsuBusUnit UUT (.*);

  wishboneMemModel slave (.clk(clk), .reset(reset), .wbOut(wbOut), .wbIn(wbIn));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset && wbOut.cyc && wbOut.stb && wbIn.ack) begin
      seenAdr.push_back(wbOut.adr);
      seenData.push_back(wbOut.datW);
      seenWe.push_back(wbOut.we);
    end
  end

  //////////////////////////////////////////////////
  // Bus and status rules
  //////////////////////////////////////////////////

  selFull: assert property (@(posedge clk) disable iff (reset)
    wbOut.stb |-> wbOut.sel == 4'hf)
    else begin
      errorCount++;
      $display("Byte selects were not all set during a bus cycle");
    end

  cycWithStb: assert property (@(posedge clk) disable iff (reset)
    wbOut.cyc == wbOut.stb)
    else begin
      errorCount++;
      $display("cyc and stb did not move together");
    end

  completePulse: assert property (@(posedge clk) disable iff (reset)
    transComplete |=> !transComplete)
    else begin
      errorCount++;
      $display("transComplete stayed high for more than one cycle");
    end

  ackPulse: assert property (@(posedge clk) disable iff (reset)
    cacheBusAck |=> !cacheBusAck)
    else begin
      errorCount++;
      $display("cacheBusAck stayed high for more than one cycle");
    end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Memory model contents before any write
  function automatic logic [31:0] initialWord(input logic [31:0] address);
    return (address & 32'h3fc) ^ fillPattern;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else begin
      errorCount++;
      $display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkCycle(input int index, input logic write, input logic [31:0] address);
    checkValue("bus we", write, seenWe[index]);
    checkValue("bus adr", address, seenAdr[index]);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrorsAtStart = errorCount;
  endtask

  task automatic endTest();
    testsRun++;
    if (errorCount == testErrorsAtStart) begin
      testsOk++;
      $display("%s ok", testName);
    end else begin
      $display("%s had %0d errors", testName, errorCount - testErrorsAtStart);
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout in %s, %s", testName, what);
    $display("tests failed");
    $finish;
  endtask

  task automatic startUncached(input logic write, input logic [31:0] address,
                               input logic [31:0] data);
    request.rw = write ? 2'b01 : 2'b10;
    request.cacheable = 1'b0;
    request.address.byteAddress = address;
    request.writeData = data;
  endtask

  task automatic clearRequest();
    request.rw = 2'b00;
  endtask

  task automatic waitForTransComplete();
    int count;
    count = 0;
    while (!transComplete && count < timeoutCycles) begin
      @(negedge clk);
      count++;
    end
    if (!transComplete) stopOnTimeout("transComplete never came");
  endtask

  // Optionally checks that the processor stays stalled for the whole line
  task automatic waitForCacheBusAck(input logic checkStall);
    int count;
    count = 0;
    while (!cacheBusAck && count < timeoutCycles) begin
      @(negedge clk);
      count++;
      if (checkStall) checkValue("busStall", 1, busStall);
    end
    if (!cacheBusAck) stopOnTimeout("cacheBusAck never came");
  endtask

  task automatic waitForIdle();
    int count;
    count = 0;
    while (busCommitted && count < timeoutCycles) begin
      @(negedge clk);
      count++;
    end
    if (busCommitted) stopOnTimeout("busCommitted never fell");
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    errorCount = 0;
    testsRun = 0;
    testsOk = 0;
    reset = 1'b1;
    request = '0;
    ignoreRequest = 1'b0;
    cpuBusy = 1'b0;
    fetchLine = 1'b0;
    writeLine = 1'b0;
    lineAddress = '0;
    lineIn = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    beginTest("idleAfterReset");
    repeat (10) begin
      @(negedge clk);
      checkValue("cyc", 0, wbOut.cyc);
      checkValue("busStall", 0, busStall);
      checkValue("busCommitted", 0, busCommitted);
    end
    endTest();

    beginTest("uncachedStore");
    firstBeat = seenAdr.size();
    startUncached(1'b1, 32'h40, 32'hcafe1234);
    waitForTransComplete();
    clearRequest();
    waitForIdle();
    checkValue("bus cycles", 1, seenAdr.size() - firstBeat);
    checkCycle(firstBeat, 1'b1, 32'h40);
    checkValue("write data", 32'hcafe1234, seenData[firstBeat]);
    checkValue("memory word", 32'hcafe1234, slave.mem[32'h40 >> 2]);
    endTest();

    beginTest("uncachedLoad");
    firstBeat = seenAdr.size();
    startUncached(1'b0, 32'h84, '0);
    waitForTransComplete();
    checkValue("readData", initialWord(32'h84), readData);
    clearRequest();
    waitForIdle();
    checkValue("bus cycles", 1, seenAdr.size() - firstBeat);
    checkCycle(firstBeat, 1'b0, 32'h84);
    endTest();

    beginTest("lineFetch");
    firstBeat = seenAdr.size();
    lineAddress.byteAddress = 32'h1a8;
    fetchLine = 1'b1;
    waitForCacheBusAck(1'b0);
    fetchLine = 1'b0;
    @(negedge clk);
    checkValue("bus cycles", 4, seenAdr.size() - firstBeat);
    for (int i = 0; i < 4; i++) begin
      checkCycle(firstBeat + i, 1'b0, 32'(32'h1a0 + 4 * i));
      checkValue("lineOut word", initialWord(32'(32'h1a0 + 4 * i)), lineOut[i]);
    end
    waitForIdle();
    endTest();

    beginTest("lineWriteback");
    firstBeat = seenAdr.size();
    for (int i = 0; i < 4; i++) begin
      lineIn[i] = 32'(32'hb0de0000 + 32'h1111 * i);
    end
    lineAddress.byteAddress = 32'h200;
    writeLine = 1'b1;
    waitForCacheBusAck(1'b1);
    writeLine = 1'b0;
    @(negedge clk);
    checkValue("bus cycles", 4, seenAdr.size() - firstBeat);
    for (int i = 0; i < 4; i++) begin
      checkCycle(firstBeat + i, 1'b1, 32'(32'h200 + 4 * i));
      checkValue("write data", lineIn[i], seenData[firstBeat + i]);
      checkValue("memory word", lineIn[i], slave.mem[(32'h200 >> 2) + i]);
    end
    waitForIdle();
    endTest();

    // A second load waits behind the busy processor
    beginTest("cpuBusyHold");
    cpuBusy = 1'b1;
    startUncached(1'b0, 32'h10, '0);
    waitForTransComplete();
    checkValue("readData", initialWord(32'h10), readData);
    startUncached(1'b0, 32'h14, '0);
    firstBeat = seenAdr.size();
    repeat (8) begin
      @(negedge clk);
      checkValue("busCommitted", 1, busCommitted);
      checkValue("cyc", 0, wbOut.cyc);
    end
    checkValue("bus cycles", 0, seenAdr.size() - firstBeat);
    cpuBusy = 1'b0;
    waitForTransComplete();
    checkValue("readData", initialWord(32'h14), readData);
    clearRequest();
    waitForIdle();
    checkCycle(firstBeat, 1'b0, 32'h14);
    endTest();

    beginTest("storeBeforeFetch");
    firstBeat = seenAdr.size();
    lineAddress.byteAddress = 32'h120;
    startUncached(1'b1, 32'h300, 32'h600dbeef);
    fetchLine = 1'b1;
    waitForTransComplete();
    clearRequest();
    waitForCacheBusAck(1'b0);
    fetchLine = 1'b0;
    @(negedge clk);
    checkValue("bus cycles", 5, seenAdr.size() - firstBeat);
    checkCycle(firstBeat, 1'b1, 32'h300);
    for (int i = 0; i < 4; i++) begin
      checkCycle(firstBeat + 1 + i, 1'b0, 32'(32'h120 + 4 * i));
      checkValue("lineOut word", initialWord(32'(32'h120 + 4 * i)), lineOut[i]);
    end
    waitForIdle();
    endTest();

    $display("%0d of %0d tests ok, %0d check errors", testsOk, testsRun, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tb.f
verilog/lsuCachePkg.sv
verilog/wishbonePkg.sv
verilog/lsuBusFsm.sv
verilog/lineBuffer.sv
verilog/wishboneMaster.sv
verilog/lsuBusUnit.sv
testbench/wishboneMemModel.sv
testbench/lsuBusUnitTb.sv
